// File: Bender.yml
package:
  name: khu_sensor

sources:
  - logic/sensor_pkg.sv
  - logic/ads1292_spi_master.sv
  - logic/ads1292_controller.sv
  - logic/uart_tx.sv
  - logic/sensor_core.sv
  - logic/khu_sensor_top.sv
  - target: simulation
    files:
      - testbench/khu_sensor_props.sv
      - testbench/tb_khu_sensor_top.sv

// File: logic/ads1292_controller.sv
`default_nettype none

module ads1292_controller import sensor_pkg::*; (
	input  wire         i_clk,
	input  wire         i_arst_n,
	// Core side
	input  wire         i_ads_req,
	input  var ads_op_t i_ads_op,
	input  wire byte_t  i_ads_addr,
	input  wire byte_t  i_ads_data,
	output logic        o_ads_busy,
	output frame_t      o_frame,
	output logic        o_frame_valid,
	input  wire         i_arm_rdatac,   // Continuous read mode active
	output logic        o_overrun,      // Sticky
	// Pins
	input  wire         i_drdy_n,
	output logic        o_csn,
	// SPI master side
	output logic        o_spi_start,
	output byte_t       o_spi_tx,
	input  wire byte_t  i_spi_rx,
	input  wire         i_spi_done
);

	ctrl_state_t state;
	ads_op_t     op_q;
	byte_t       addr_q;
	byte_t       data_q;
	logic [3:0]  byte_idx;     // Byte position within the transaction
	logic [3:0]  byte_last;
	logic [$clog2(SPI_HALF_DIV)-1:0] hold_cnt;  // CSN high time
	logic        drdy_meta;
	logic        drdy_sync;
	logic        drdy_prev;
	logic        drdy_fall;

	// ==========================================================================
	// DRDY synchronizer and falling edge detect
	// ==========================================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			drdy_meta <= 1'b1;
			drdy_sync <= 1'b1;
			drdy_prev <= 1'b1;
		end else begin
			drdy_meta <= i_drdy_n;
			drdy_sync <= drdy_meta;
			drdy_prev <= drdy_sync;
		end
	end

	assign drdy_fall = drdy_prev & ~drdy_sync;

	// Byte list per operation
	always_comb begin
		case (op_q)
			OP_CMD:  byte_last = 4'd0;
			OP_WREG: byte_last = 4'd2;  // Opcode, count, data
			default: byte_last = 4'(FRAME_BYTES - 1);
		endcase
		case (op_q)
			OP_CMD:  o_spi_tx = data_q;
			OP_WREG: begin
				if (byte_idx == 4'd0)
					o_spi_tx = CMD_START_OP_WREG | addr_q;
				else if (byte_idx == 4'd1)
					o_spi_tx = 8'h00;  // One register
				else
					o_spi_tx = data_q;
			end
			default: o_spi_tx = 8'h00;  // Dummy bytes clock out the frame
		endcase
	end

	// ==========================================================================
	// Transaction FSM
	// ==========================================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state         <= CT_IDLE;
			op_q          <= OP_CMD;
			byte_idx      <= '0;
			hold_cnt      <= '0;
			o_ads_busy    <= 1'b0;
			o_csn         <= 1'b1;
			o_spi_start   <= 1'b0;
			o_frame_valid <= 1'b0;
			o_overrun     <= 1'b0;
		end else begin
			o_spi_start   <= 1'b0;
			o_frame_valid <= 1'b0;
			// New frame before the current one is read out
			if (drdy_fall && op_q == OP_READ && (state == CT_START || state == CT_WAIT))
				o_overrun <= 1'b1;
			case (state)
				CT_IDLE: begin
					byte_idx <= '0;
					if (i_ads_req) begin
						op_q       <= i_ads_op;
						o_ads_busy <= 1'b1;
						o_csn      <= 1'b0;  // One clock ahead of the first byte
						state      <= CT_START;
					end else if (drdy_fall && i_arm_rdatac) begin
						op_q       <= OP_READ;
						o_ads_busy <= 1'b1;
						o_csn      <= 1'b0;
						state      <= CT_START;
					end
				end
				CT_START: begin
					o_spi_start <= 1'b1;
					state       <= CT_WAIT;
				end
				CT_WAIT: if (i_spi_done) begin
					if (byte_idx == byte_last) begin
						o_csn         <= 1'b1;
						hold_cnt      <= '0;
						o_frame_valid <= (op_q == OP_READ);
						state         <= CT_HOLD;
					end else begin
						byte_idx <= byte_idx + 1'b1;
						state    <= CT_START;
					end
				end
				CT_HOLD: begin
					if (hold_cnt == SPI_HALF_DIV - 1) begin
						o_ads_busy <= 1'b0;
						state      <= CT_IDLE;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				default: state <= CT_IDLE;
			endcase
		end
	end

	// Request payload and frame assembly
	always_ff @(posedge i_clk) begin
		if (state == CT_IDLE && i_ads_req) begin
			addr_q <= i_ads_addr;
			data_q <= i_ads_data;
		end
		if (state == CT_WAIT && i_spi_done && op_q == OP_READ)
			o_frame <= {o_frame[63:0], i_spi_rx};  // Status byte ends on top
	end

endmodule

`default_nettype wire

// File: logic/ads1292_spi_master.sv
`default_nettype none

module ads1292_spi_master import sensor_pkg::*; (
	input  wire        i_clk,
	input  wire        i_arst_n,
	input  wire        i_spi_start,   // One-cycle request
	input  wire byte_t i_spi_tx,
	output byte_t      o_spi_rx,      // Valid with o_spi_done
	output logic       o_spi_busy,
	output logic       o_spi_done,
	output logic       o_sclk,        // Mode 1, idles low
	output logic       o_mosi,
	input  wire        i_miso
);

	logic [$clog2(SPI_HALF_DIV)-1:0] half_cnt;  // Clocks inside one half period
	logic [3:0] edge_cnt;   // 16 SCLK edges per byte
	byte_t      shreg;      // TX leaves at the top, RX enters at the bottom
	logic       half_end;

	assign half_end = (half_cnt == SPI_HALF_DIV - 1);
	assign o_spi_rx = shreg;

	// ==========================================================================
	// Clock divider and edge counter
	// ==========================================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			half_cnt   <= '0;
			edge_cnt   <= '0;
			o_spi_busy <= 1'b0;
			o_spi_done <= 1'b0;
			o_sclk     <= 1'b0;
			o_mosi     <= 1'b0;
		end else begin
			o_spi_done <= 1'b0;
			if (!o_spi_busy) begin
				if (i_spi_start) begin
					o_spi_busy <= 1'b1;  // Busy from the next clock
					half_cnt   <= '0;
					edge_cnt   <= '0;
				end
			end else if (half_end) begin
				half_cnt <= '0;
				o_sclk   <= ~o_sclk;
				edge_cnt <= edge_cnt + 1'b1;
				// Rising edge launches the next bit
				if (!o_sclk)
					o_mosi <= shreg[7];
				// Last falling edge ends the byte
				if (edge_cnt == 4'd15) begin
					o_spi_busy <= 1'b0;
					o_spi_done <= 1'b1;
				end
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// Shift register, MSB first
	always_ff @(posedge i_clk) begin
		if (!o_spi_busy && i_spi_start) begin
			shreg <= i_spi_tx;
		end else if (o_spi_busy && half_end) begin
			if (!o_sclk)
				shreg <= {shreg[6:0], 1'b0};  // Bit just went out on MOSI
			else
				shreg[0] <= i_miso;           // Sample on falling SCLK
		end
	end

endmodule

`default_nettype wire

// File: logic/khu_sensor_top.sv
`default_nettype none

module khu_sensor_top import sensor_pkg::*; (
	input  wire  i_clk,
	input  wire  i_arst_n,
	input  wire  i_run,
	output logic o_chip_set,
	output logic o_run_set,
	output logic o_core_busy,
	output logic o_overrun,
	output logic o_uart_txd,
	// ADS1292 pins
	output logic o_ads_sclk,
	output logic o_ads_mosi,
	input  wire  i_ads_miso,
	input  wire  i_ads_drdy_n,
	output logic o_ads_reset_n,
	output logic o_ads_start,
	output logic o_ads_csn
);

	// ==========================================================================
	// Internal connections
	// ==========================================================================
	logic    ads_req;
	ads_op_t ads_op;
	byte_t   ads_addr;
	byte_t   ads_data;
	logic    ads_busy;
	frame_t  frame;
	logic    frame_valid;
	logic    arm_rdatac;
	logic    spi_start;
	byte_t   spi_tx;
	byte_t   spi_rx;
	logic    spi_done;
	logic    tx_valid;
	byte_t   tx_data;
	logic    tx_ready;

	assign o_ads_reset_n = i_arst_n;  // Chip leaves reset with the design

	sensor_core u_sensor_core (
		.i_clk(i_clk), .i_arst_n(i_arst_n), .i_run(i_run),
		.o_chip_set(o_chip_set), .o_run_set(o_run_set), .o_core_busy(o_core_busy),
		.o_ads_start_pin(o_ads_start),
		.o_ads_req(ads_req), .o_ads_op(ads_op), .o_ads_addr(ads_addr),
		.o_ads_data(ads_data), .i_ads_busy(ads_busy),
		.i_frame(frame), .i_frame_valid(frame_valid), .o_arm_rdatac(arm_rdatac),
		.o_tx_valid(tx_valid), .o_tx_data(tx_data), .i_tx_ready(tx_ready)
	);

	ads1292_controller u_ads1292_controller (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_ads_req(ads_req), .i_ads_op(ads_op), .i_ads_addr(ads_addr),
		.i_ads_data(ads_data), .o_ads_busy(ads_busy),
		.o_frame(frame), .o_frame_valid(frame_valid), .i_arm_rdatac(arm_rdatac),
		.o_overrun(o_overrun), .i_drdy_n(i_ads_drdy_n), .o_csn(o_ads_csn),
		.o_spi_start(spi_start), .o_spi_tx(spi_tx), .i_spi_rx(spi_rx),
		.i_spi_done(spi_done)
	);

	// SPI busy stays internal
	ads1292_spi_master u_ads1292_spi_master (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_spi_start(spi_start), .i_spi_tx(spi_tx), .o_spi_rx(spi_rx),
		.o_spi_busy(), .o_spi_done(spi_done),
		.o_sclk(o_ads_sclk), .o_mosi(o_ads_mosi), .i_miso(i_ads_miso)
	);

	uart_tx u_uart_tx (
		.i_clk(i_clk), .i_arst_n(i_arst_n),
		.i_tx_valid(tx_valid), .i_tx_data(tx_data), .o_tx_ready(tx_ready),
		.o_txd(o_uart_txd)
	);

endmodule

`default_nettype wire

// File: logic/sensor_core.sv
`default_nettype none

module sensor_core import sensor_pkg::*; (
	input  wire         i_clk,
	input  wire         i_arst_n,
	input  wire         i_run,
	output logic        o_chip_set,
	output logic        o_run_set,
	output logic        o_core_busy,
	output logic        o_ads_start_pin,
	// ADS1292 controller
	output logic        o_ads_req,
	output ads_op_t     o_ads_op,
	output byte_t       o_ads_addr,
	output byte_t       o_ads_data,
	input  wire         i_ads_busy,
	input  wire frame_t i_frame,
	input  wire         i_frame_valid,
	output logic        o_arm_rdatac,
	// UART transmitter
	output logic        o_tx_valid,
	output byte_t       o_tx_data,
	input  wire         i_tx_ready
);

	core_state_t state;
	core_state_t ret_state;  // Resume point after CO_WAIT
	logic [$clog2(CFG_LEN+1)-1:0] cfg_idx;
	logic [3:0]  byte_cnt;   // 0 is the sync byte
	logic [79:0] pkt;        // Sync byte and latched frame

	assign o_tx_data = pkt[79:72];

	// Hand a request to the controller, then wait in CO_WAIT
	task automatic issue(input ads_op_t op, input byte_t addr, input byte_t data,
		input core_state_t ret);
		o_ads_req  <= 1'b1;
		o_ads_op   <= op;
		o_ads_addr <= addr;
		o_ads_data <= data;
		ret_state  <= ret;
		state      <= CO_WAIT;
	endtask

	// ==========================================================================
	// Setup, run control and packet FSM
	// ==========================================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state           <= CO_BOOT;
			ret_state       <= CO_BOOT;
			cfg_idx         <= '0;
			byte_cnt        <= '0;
			o_chip_set      <= 1'b0;
			o_run_set       <= 1'b0;
			o_core_busy     <= 1'b0;
			o_ads_start_pin <= 1'b0;
			o_ads_req       <= 1'b0;
			o_ads_op        <= OP_CMD;
			o_ads_addr      <= '0;
			o_ads_data      <= '0;
			o_arm_rdatac    <= 1'b0;
			o_tx_valid      <= 1'b0;
		end else begin
			case (state)
				CO_BOOT: if (!i_ads_busy) begin
					o_core_busy <= 1'b1;
					issue(OP_CMD, 8'h00, CMD_SDATAC, CO_CFG);
				end
				CO_WAIT: begin
					if (o_ads_req) begin
						if (i_ads_busy)
							o_ads_req <= 1'b0;  // Accepted
					end else if (!i_ads_busy) begin
						state <= ret_state;
					end
				end
				CO_CFG: begin
					if (cfg_idx == CFG_LEN) begin
						o_chip_set  <= 1'b1;
						o_core_busy <= 1'b0;
						state       <= CO_READY;
					end else begin
						issue(OP_WREG, CFG_TABLE[cfg_idx][15:8], CFG_TABLE[cfg_idx][7:0],
							CO_CFG);
						cfg_idx <= cfg_idx + 1'b1;
					end
				end
				CO_READY: begin
					if (i_frame_valid) begin
						o_arm_rdatac <= 1'b0;  // No new reads until the packet is out
						o_core_busy  <= 1'b1;
						o_tx_valid   <= 1'b1;
						byte_cnt     <= '0;
						state        <= CO_SEND;
					end else if (!i_run && o_run_set) begin
						o_arm_rdatac <= 1'b0;
						o_run_set    <= 1'b0;
						o_core_busy  <= 1'b1;
						state        <= CO_DISARM;
					end else if (i_run && !o_run_set && !i_ads_busy) begin
						o_ads_start_pin <= 1'b1;
						o_core_busy     <= 1'b1;
						issue(OP_CMD, 8'h00, CMD_RDATAC, CO_ARM);
					end
				end
				CO_ARM: begin
					o_arm_rdatac <= 1'b1;
					o_run_set    <= 1'b1;
					o_core_busy  <= 1'b0;
					state        <= CO_READY;
				end
				// Let a read already under way finish
				CO_DISARM: if (!i_ads_busy)
					issue(OP_CMD, 8'h00, CMD_SDATAC, CO_STOP);
				CO_STOP: begin
					o_ads_start_pin <= 1'b0;
					o_core_busy     <= 1'b0;
					state           <= CO_READY;
				end
				CO_SEND: if (i_tx_ready) begin
					if (byte_cnt == FRAME_BYTES) begin
						o_tx_valid <= 1'b0;
						state      <= CO_TXEND;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				CO_TXEND: if (i_tx_ready) begin  // Stop bit of the last byte done
					o_core_busy  <= 1'b0;
					o_arm_rdatac <= 1'b1;
					state        <= CO_READY;
				end
				default: state <= CO_BOOT;
			endcase
		end
	end

	// Packet shifter, MSB byte first
	always_ff @(posedge i_clk) begin
		if (state == CO_READY && i_frame_valid)
			pkt <= {SYNC_BYTE, i_frame};
		else if (state == CO_SEND && i_tx_ready)
			pkt <= {pkt[71:0], 8'h00};
	end

endmodule

`default_nettype wire

// File: logic/sensor_pkg.sv
`default_nettype none

package sensor_pkg;

	// ==========================================================================
	// Data widths
	// ==========================================================================
	typedef logic [7:0]  byte_t;   // One SPI or UART byte
	typedef logic [71:0] frame_t;  // Status word, CH1, CH2 (24 bits each)

	// Operation requested from the ADS1292 controller
	typedef enum logic [1:0] {OP_CMD, OP_WREG, OP_READ} ads_op_t;

	// ADS1292 opcodes
	localparam byte_t CMD_SDATAC        = 8'h11;  // Stop continuous read
	localparam byte_t CMD_RDATAC        = 8'h10;  // Continuous read
	localparam byte_t CMD_START_OP_WREG = 8'h40;  // OR'd with register address

	// Setup table as {addr, data}, entry 0 written first
	localparam int CFG_LEN = 3;
	localparam logic [CFG_LEN-1:0][15:0] CFG_TABLE =
		{16'h04_00, 16'h02_A0, 16'h01_02};

	// ==========================================================================
	// Timing and framing
	// ==========================================================================
	localparam int SPI_HALF_DIV      = 4;      // Clocks per SCLK half period
	localparam int UART_CLKS_PER_BIT = 8;
	localparam int FRAME_BYTES       = 9;      // 72-bit frame
	localparam byte_t SYNC_BYTE      = 8'hA5;  // Packet header toward the PC

	// Sensor core sequencing
	typedef enum logic [3:0] {CO_BOOT, CO_CFG, CO_WAIT, CO_READY, CO_ARM,
		CO_DISARM, CO_STOP, CO_SEND, CO_TXEND} core_state_t;

	// ADS1292 transaction sequencing
	typedef enum logic [1:0] {CT_IDLE, CT_START, CT_WAIT, CT_HOLD}
		ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/uart_tx.sv
`default_nettype none

module uart_tx import sensor_pkg::*; (
	input  wire        i_clk,
	input  wire        i_arst_n,
	input  wire        i_tx_valid,
	input  wire byte_t i_tx_data,
	output logic       o_tx_ready,  // Low while a byte is on the line
	output logic       o_txd
);

	logic [9:0] shreg;  // Stop, data LSB first, start
	logic [$clog2(UART_CLKS_PER_BIT)-1:0] baud_cnt;
	logic [3:0] bit_cnt;

	assign o_txd = shreg[0];

	// ==========================================================================
	// 8N1 serializer
	// ==========================================================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			shreg      <= '1;   // Line idles high
			baud_cnt   <= '0;
			bit_cnt    <= '0;
			o_tx_ready <= 1'b1;
		end else if (o_tx_ready) begin
			if (i_tx_valid) begin
				shreg      <= {1'b1, i_tx_data, 1'b0};
				baud_cnt   <= '0;
				bit_cnt    <= '0;
				o_tx_ready <= 1'b0;
			end
		end else if (baud_cnt == UART_CLKS_PER_BIT - 1) begin
			baud_cnt <= '0;
			shreg    <= {1'b1, shreg[9:1]};  // Next bit, fill with idle
			bit_cnt  <= bit_cnt + 1'b1;
			if (bit_cnt == 4'd9)
				o_tx_ready <= 1'b1;  // End of stop bit
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: sources.f
logic/sensor_pkg.sv
logic/ads1292_spi_master.sv
logic/ads1292_controller.sv
logic/uart_tx.sv
logic/sensor_core.sv
logic/khu_sensor_top.sv
testbench/khu_sensor_props.sv
testbench/tb_khu_sensor_top.sv

// File: testbench/khu_sensor_props.sv
`default_nettype none

module khu_sensor_props (
	input wire i_clk,
	input wire i_arst_n,
	input wire i_sclk,
	input wire i_csn,
	input wire i_txd,
	input wire i_core_busy,
	input wire i_run_set,
	input wire i_start
);

	int prop_fails = 0;  // Summed into the end of run summary

	// ==========================================================================
	// Pin rules
	// ==========================================================================
	// SCLK parked low while the ADS1292 is deselected
	sclk_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_csn |-> !i_sclk)
		else begin
			prop_fails++;
			$error("SCLK high while CSN is high");
		end

	// Line idle outside packets
	txd_idle: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!i_core_busy |-> i_txd)
		else begin
			prop_fails++;
			$error("TXD low while the core is not busy");
		end

	run_start: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_run_set |-> i_start)  // START leads run_set
		else begin
			prop_fails++;
			$error("Run set without START high");
		end

endmodule

bind khu_sensor_top khu_sensor_props u_khu_sensor_props (
	.i_clk(i_clk),
	.i_arst_n(i_arst_n),
	.i_sclk(o_ads_sclk),
	.i_csn(o_ads_csn),
	.i_txd(o_uart_txd),
	.i_core_busy(o_core_busy),
	.i_run_set(o_run_set),
	.i_start(o_ads_start)
);

`default_nettype wire

// File: testbench/tb_khu_sensor_top.sv
`default_nettype none

module tb_khu_sensor_top import sensor_pkg::*; ();

	logic clk = 1'b0;
	logic arst_n;
	logic run;
	logic drdy_n;
	logic miso;
	wire  chip_set;
	wire  run_set;
	wire  core_busy;
	wire  overrun;
	wire  uart_txd;
	wire  ads_sclk;
	wire  ads_mosi;
	wire  ads_reset_n;
	wire  ads_start;
	wire  ads_csn;

	integer seed = 40;
	int     errors = 0;
	int     timeouts = 0;
	byte_t  mosi_q[$];      // Bytes decoded from MOSI
	byte_t  rx_q[$];        // Bytes decoded from TXD
	byte_t  mosi_sh;
	int     mosi_bits = 0;
	frame_t miso_sh = '0;   // Frame the device model shifts out
	logic   rx_busy = 1'b0;
	int     rx_cnt;
	int     rx_bit;
	byte_t  rx_sh;

	// ADS1292 register setup expected after reset
	byte_t cfg_addr[3] = '{8'h01, 8'h02, 8'h04};
	byte_t cfg_data[3] = '{8'h02, 8'hA0, 8'h00};

	khu_sensor_top u_khu_sensor_top (
		.i_clk(clk), .i_arst_n(arst_n), .i_run(run),
		.o_chip_set(chip_set), .o_run_set(run_set), .o_core_busy(core_busy),
		.o_overrun(overrun), .o_uart_txd(uart_txd),
		.o_ads_sclk(ads_sclk), .o_ads_mosi(ads_mosi), .i_ads_miso(miso),
		.i_ads_drdy_n(drdy_n), .o_ads_reset_n(ads_reset_n),
		.o_ads_start(ads_start), .o_ads_csn(ads_csn)
	);

	always #2 clk = ~clk;

	// ==========================================================================
	// ADS1292 model
	// ==========================================================================
	// Device latches MOSI on falling SCLK (mode 1)
	always @(negedge ads_sclk) begin
		if (!ads_csn) begin
			mosi_sh = {mosi_sh[6:0], ads_mosi};
			mosi_bits++;
			if (mosi_bits == 8) begin
				mosi_q.push_back(mosi_sh);
				mosi_bits = 0;
			end
		end
	end

	always @(negedge ads_csn)
		mosi_bits = 0;  // Byte boundary at select

	// MISO launched after rising SCLK, MSB first
	always @(posedge ads_sclk) begin
		#1;
		if (!ads_csn) begin
			miso    = miso_sh[71];
			miso_sh = {miso_sh[70:0], 1'b0};
		end
	end

	// ==========================================================================
	// UART sampler, 8N1
	// ==========================================================================
	always @(negedge clk) begin
		if (!arst_n) begin
			rx_busy = 1'b0;
		end else if (!rx_busy) begin
			if (!uart_txd) begin  // Start bit edge
				rx_busy = 1'b1;
				rx_cnt  = 0;
				rx_bit  = 0;
			end
		end else begin
			rx_cnt++;
			// Mid-bit sample point
			if (rx_cnt == UART_CLKS_PER_BIT / 2 + UART_CLKS_PER_BIT * rx_bit) begin
				if (rx_bit == 0) begin
					assert (uart_txd == 1'b0) else begin
						errors++;
						$display("ERROR @%0t: UART start bit not held low", $time);
					end
				end else if (rx_bit <= 8) begin
					rx_sh[rx_bit - 1] = uart_txd;  // LSB first
				end else begin
					assert (uart_txd == 1'b1) else begin
						errors++;
						$display("ERROR @%0t: UART stop bit low", $time);
					end
					rx_q.push_back(rx_sh);
					rx_busy = 1'b0;
				end
				rx_bit++;
			end
		end
	end

	// ==========================================================================
	// Helpers
	// ==========================================================================
	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("ERROR @%0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		assert (got == exp) else begin
			errors++;
			$display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		int prop_fails;
		prop_fails = u_khu_sensor_top.u_khu_sensor_props.prop_fails;
		$display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, prop_fails);
		if (errors == 0 && timeouts == 0 && prop_fails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timed out while waiting for %s", what);
	endtask

	function automatic frame_t random_frame();
		logic [95:0] r;
		r = {$random(seed), $random(seed), $random(seed)};
		return r[71:0];
	endfunction

	// One DRDY pulse with a fresh frame behind it
	task automatic pulse_drdy(input frame_t f);
		@(posedge clk);
		#1;
		miso_sh = f;
		drdy_n  = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		drdy_n = 1'b1;
	endtask

	// ==========================================================================
	// Stimulus and scoreboard
	// ==========================================================================
	// Idle levels, setup, run start, frames and run stop in order
	task automatic run_sequence();
		int     n;
		int     i;
		int     k;
		int     nframes;
		int     gap;
		frame_t frame;
		byte_t  exp_setup[$];

		// Idle pin levels right after release
		check_level(ads_reset_n, 1'b1, "ADS1292 reset pin");
		check_level(ads_csn, 1'b1, "CSN");
		check_level(uart_txd, 1'b1, "TXD");
		check_level(ads_sclk, 1'b0, "SCLK");
		check_level(ads_start, 1'b0, "START");
		check_level(chip_set, 1'b0, "o_chip_set");
		check_level(run_set, 1'b0, "o_run_set");
		check_level(core_busy, 1'b0, "o_core_busy");
		check_level(overrun, 1'b0, "o_overrun");

		// SDATAC, then WREG triples
		n = 0;
		while (!chip_set && n < 20000) begin
			@(negedge clk);
			n++;
		end
		if (!chip_set) begin
			report_timeout("o_chip_set after the setup sequence");
			return;
		end
		exp_setup.push_back(8'h11);
		foreach (cfg_addr[j]) begin
			exp_setup.push_back(8'h40 | cfg_addr[j]);
			exp_setup.push_back(8'h00);
			exp_setup.push_back(cfg_data[j]);
		end
		check_count(mosi_q.size(), exp_setup.size(), "setup byte count");
		foreach (exp_setup[j])
			if (j < mosi_q.size())
				check_byte(mosi_q[j], exp_setup[j], $sformatf("setup byte %0d", j));
		mosi_q.delete();

		@(posedge clk);
		#1;
		run = 1'b1;
		n = 0;
		while (!run_set && n < 4000) begin
			@(negedge clk);
			n++;
		end
		if (!run_set) begin
			report_timeout("o_run_set after run was raised");
			return;
		end
		check_level(ads_start, 1'b1, "START after run");
		check_count(mosi_q.size(), 1, "bytes sent for run start");
		if (mosi_q.size() > 0)
			check_byte(mosi_q[0], 8'h10, "RDATAC opcode");
		mosi_q.delete();

		// Frames, each pulse after the previous packet
		nframes = 4 + ($unsigned($random(seed)) % 5);
		for (i = 0; i < nframes; i++) begin
			gap = 20 + ($unsigned($random(seed)) % 200);
			repeat (gap) @(posedge clk);
			frame = random_frame();
			pulse_drdy(frame);
			n = 0;
			while (rx_q.size() < FRAME_BYTES + 1 && n < 8000) begin
				@(negedge clk);
				n++;
			end
			if (rx_q.size() < FRAME_BYTES + 1) begin
				report_timeout($sformatf("the UART packet of frame %0d", i));
				return;
			end
			check_byte(rx_q[0], 8'hA5, $sformatf("frame %0d sync byte", i));
			for (k = 0; k < 9; k++)
				check_byte(rx_q[k + 1], frame[71 - 8 * k -: 8],
					$sformatf("frame %0d byte %0d", i, k));
			check_count(mosi_q.size(), 9, $sformatf("frame %0d read length", i));
			foreach (mosi_q[j])
				check_byte(mosi_q[j], 8'h00, $sformatf("frame %0d dummy byte", i));
			check_level(overrun, 1'b0, "o_overrun");
			rx_q.delete();
			mosi_q.delete();
		end

		@(posedge clk);
		#1;
		run = 1'b0;
		n = 0;
		while (ads_start && n < 4000) begin
			@(negedge clk);
			n++;
		end
		if (ads_start) begin
			report_timeout("START to fall after run was lowered");
			return;
		end
		check_level(run_set, 1'b0, "o_run_set after stop");
		check_count(mosi_q.size(), 1, "bytes sent for run stop");
		if (mosi_q.size() > 0)
			check_byte(mosi_q[0], 8'h11, "SDATAC opcode");
		mosi_q.delete();

		// Pulses while stopped must stay unread
		repeat (2) begin
			pulse_drdy(random_frame());
			repeat (2500) @(posedge clk);
		end
		check_count(rx_q.size(), 0, "UART bytes after stop");
		check_count(mosi_q.size(), 0, "MOSI bytes after stop");
		check_level(overrun, 1'b0, "o_overrun at end");
	endtask

	initial begin
		arst_n = 1'b0;
		run    = 1'b0;
		drdy_n = 1'b1;
		miso   = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;
		#1;
		run_sequence();
		finish_run();
	end

endmodule

`default_nettype wire
